// ==== source/ooo_pkg.sv ====
package ooo_pkg;

    // tag width, rob depth must be 2**ROB_TAG_W
    localparam int ROB_TAG_W = 3;

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // major opcodes handled by this back end
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    // M extension marker in funct7
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // same instruction word, register or immediate view
    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } rv_inst_u;

    // decoded instruction with operands already read
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        rv_inst_u    inst;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [4:0]  rd;
    } dispatch_t;

    // rob to execution unit
    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;
        rv_inst_u    inst;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
    } issue_t;

    // unit result, also the cdb format
    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;
        logic [31:0] data;
    } result_t;

    typedef enum logic [1:0] {
        ROB_EMPTY = 2'd0,
        ROB_WAIT  = 2'd1,
        ROB_DONE  = 2'd2
    } rob_status_e;

    typedef struct packed {
        rob_status_e status;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
    } rob_entry_t;

    // retire strobe toward the register file
    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
    } commit_t;

endpackage

// ==== source/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int ROB_DEPTH = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  ooo_pkg::dispatch_t dispatch_i,
    input  ooo_pkg::result_t   cdb_i,
    output ooo_pkg::issue_t    alu_issue_o,
    output ooo_pkg::issue_t    mul_issue_o,
    output ooo_pkg::commit_t   commit_o,
    output logic               full_o
);
    import ooo_pkg::*;

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    rob_entry_t       rob_q [ROB_DEPTH];
    rob_tag_t         head_q;
    rob_tag_t         tail_q;
    logic [CNT_W-1:0] count_q;
    logic             is_mul;
    logic             cdb_hits_head;
    logic             head_ready;
    logic [31:0]      head_data;
    issue_t           issue_d;
    issue_t           alu_issue_q;
    issue_t           mul_issue_q;
    commit_t          commit_q;

    assign full_o = (count_q == CNT_W'(ROB_DEPTH));

    // OP group with the muldiv funct7 goes to the multiplier
    assign is_mul = (dispatch_i.inst.r_fields.opcode == OPC_OP) &&
                    (dispatch_i.inst.r_fields.funct7 == FUNCT7_MULDIV);

    always_comb begin
        issue_d.valid   = dispatch_i.valid;
        // tag is simply the slot index
        issue_d.tag     = tail_q;
        issue_d.inst    = dispatch_i.inst;
        issue_d.rs1_val = dispatch_i.rs1_val;
        issue_d.rs2_val = dispatch_i.rs2_val;
    end

    // cdb result for the waiting head retires straight away
    assign cdb_hits_head = cdb_i.valid && (cdb_i.tag == head_q) &&
                           (rob_q[head_q].status == ROB_WAIT);
    assign head_ready    = (rob_q[head_q].status == ROB_DONE) || cdb_hits_head;
    assign head_data     = cdb_hits_head ? cdb_i.data : rob_q[head_q].data;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q            <= '0;
            tail_q            <= '0;
            count_q           <= '0;
            alu_issue_q.valid <= 1'b0;
            mul_issue_q.valid <= 1'b0;
            commit_q.valid    <= 1'b0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                rob_q[i].status <= ROB_EMPTY;
            end
        end else begin
            // issue register, one unit per dispatch
            alu_issue_q       <= issue_d;
            alu_issue_q.valid <= dispatch_i.valid && !is_mul;
            mul_issue_q       <= issue_d;
            mul_issue_q.valid <= dispatch_i.valid && is_mul;

            // allocate tail
            if (dispatch_i.valid) begin
                rob_q[tail_q].status <= ROB_WAIT;
                rob_q[tail_q].pc     <= dispatch_i.pc;
                rob_q[tail_q].rd     <= dispatch_i.rd;
                tail_q               <= tail_q + 1'b1;
            end

            // writeback from the bus
            if (cdb_i.valid && !cdb_hits_head) begin
                rob_q[cdb_i.tag].status <= ROB_DONE;
                rob_q[cdb_i.tag].data   <= cdb_i.data;
            end

            // in-order retire, one per cycle
            commit_q.valid <= head_ready;
            commit_q.tag   <= head_q;
            commit_q.pc    <= rob_q[head_q].pc;
            commit_q.rd    <= rob_q[head_q].rd;
            commit_q.data  <= head_data;
            if (head_ready) begin
                rob_q[head_q].status <= ROB_EMPTY;
                head_q               <= head_q + 1'b1;
            end

            case ({dispatch_i.valid, head_ready})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign alu_issue_o = alu_issue_q;
    assign mul_issue_o = mul_issue_q;
    assign commit_o    = commit_q;

    // source must stall on full
    a_no_dispatch_full: assert property (
        @(posedge clk) disable iff (rst) dispatch_i.valid |-> !full_o
    ) else $error("dispatch while rob full");

    // arbiter only broadcasts tags that are still outstanding
    a_cdb_tag_waiting: assert property (
        @(posedge clk) disable iff (rst)
        cdb_i.valid |-> (rob_q[cdb_i.tag].status == ROB_WAIT)
    ) else $error("cdb tag %0d not waiting", cdb_i.tag);

    // each dispatch becomes exactly one issue next cycle
    a_single_issue: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({alu_issue_o.valid, mul_issue_o.valid}) &&
        ((alu_issue_o.valid || mul_issue_o.valid) == $past(dispatch_i.valid))
    ) else $error("issue does not follow dispatch");

endmodule

// ==== source/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit (
    input  logic             clk,
    input  logic             rst,
    input  ooo_pkg::issue_t  issue_i,
    output ooo_pkg::result_t result_o
);
    import ooo_pkg::*;

    // funct3 encodings of the integer ops
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    logic        is_imm;
    logic [2:0]  funct3;
    logic        alt;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  shamt;
    logic [31:0] alu_out;
    result_t     result_q;

    always_comb begin
        is_imm = (issue_i.inst.i_fields.opcode == OPC_OP_IMM);
        // funct3 sits at the same place in both views
        funct3 = issue_i.inst.r_fields.funct3;
        // bit 30, also imm12[10] as the srai marker
        alt    = issue_i.inst.r_fields.funct7[5];
        op_a   = issue_i.rs1_val;
        if (is_imm) begin
            op_b = {{20{issue_i.inst.i_fields.imm12[11]}}, issue_i.inst.i_fields.imm12};
        end else begin
            op_b = issue_i.rs2_val;
        end
        shamt = op_b[4:0];

        case (funct3)
            // no subi, alt only counts for R-type
            F3_ADD:  alu_out = (alt && !is_imm) ? (op_a - op_b) : (op_a + op_b);
            F3_SLL:  alu_out = op_a << shamt;
            F3_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            F3_SLTU: alu_out = {31'b0, op_a < op_b};
            F3_XOR:  alu_out = op_a ^ op_b;
            F3_SR:   alu_out = alt ? $unsigned($signed(op_a) >>> shamt) : (op_a >> shamt);
            F3_OR:   alu_out = op_a | op_b;
            F3_AND:  alu_out = op_a & op_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_q.valid <= 1'b0;
        end else begin
            result_q.valid <= issue_i.valid;
            result_q.tag   <= issue_i.tag;
            result_q.data  <= alu_out;
        end
    end

    assign result_o = result_q;

    // rob routing keeps M-extension ops away from here
    a_alu_opcode: assert property (
        @(posedge clk) disable iff (rst)
        issue_i.valid |-> ((issue_i.inst.r_fields.opcode == OPC_OP_IMM) ||
                           ((issue_i.inst.r_fields.opcode == OPC_OP) &&
                            (issue_i.inst.r_fields.funct7 != FUNCT7_MULDIV)))
    ) else $error("alu issued a non-integer opcode");

endmodule

// ==== source/mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit #(
    parameter int MUL_STAGES = 3
) (
    input  logic             clk,
    input  logic             rst,
    input  ooo_pkg::issue_t  issue_i,
    output ooo_pkg::result_t result_o
);
    import ooo_pkg::*;

    result_t     stage_q [MUL_STAGES];
    logic [31:0] product;

    // low half is identical for signed and unsigned operands
    assign product = issue_i.rs1_val * issue_i.rs2_val;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MUL_STAGES; i++) begin
                stage_q[i].valid <= 1'b0;
            end
        end else begin
            // first stage does the multiply
            stage_q[0].valid <= issue_i.valid;
            stage_q[0].tag   <= issue_i.tag;
            stage_q[0].data  <= product;
            // rest only delays, one op per stage in flight
            for (int i = 1; i < MUL_STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign result_o = stage_q[MUL_STAGES-1];

endmodule

// ==== source/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter #(
    parameter int ROB_DEPTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  ooo_pkg::result_t alu_result_i,
    input  ooo_pkg::result_t mul_result_i,
    output ooo_pkg::result_t cdb_o
);
    import ooo_pkg::*;

    localparam int PTR_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    // index 0 is the alu queue, 1 the multiplier queue
    result_t          in_res [2];
    result_t          q_mem [2][ROB_DEPTH];
    logic [PTR_W-1:0] rd_ptr_q [2];
    logic [PTR_W-1:0] wr_ptr_q [2];
    logic [CNT_W-1:0] cnt_q [2];
    result_t          cand [2];
    logic [1:0]       avail;
    logic [1:0]       grant;
    logic [1:0]       push;
    logic [1:0]       pop;
    logic             rr_q;
    result_t          cdb_q;

    assign in_res[0] = alu_result_i;
    assign in_res[1] = mul_result_i;

    always_comb begin
        for (int q = 0; q < 2; q++) begin
            // empty queue forwards the incoming result
            avail[q] = (cnt_q[q] != '0) || in_res[q].valid;
            cand[q]  = (cnt_q[q] != '0) ? q_mem[q][rd_ptr_q[q]] : in_res[q];
        end
        grant = avail;
        if (avail == 2'b11) begin
            grant        = 2'b00;
            grant[rr_q]  = 1'b1;
        end
        for (int q = 0; q < 2; q++) begin
            pop[q]  = grant[q] && (cnt_q[q] != '0);
            push[q] = in_res[q].valid && !(grant[q] && (cnt_q[q] == '0));
        end
    end

    always_ff @(posedge clk) begin
        for (int q = 0; q < 2; q++) begin
            if (push[q]) begin
                q_mem[q][wr_ptr_q[q]] <= in_res[q];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_q        <= 1'b0;
            cdb_q.valid <= 1'b0;
            for (int q = 0; q < 2; q++) begin
                rd_ptr_q[q] <= '0;
                wr_ptr_q[q] <= '0;
                cnt_q[q]    <= '0;
            end
        end else begin
            // pointer moves only on a real conflict
            if (avail == 2'b11) begin
                rr_q <= ~rr_q;
            end
            cdb_q       <= grant[1] ? cand[1] : cand[0];
            cdb_q.valid <= |grant;
            for (int q = 0; q < 2; q++) begin
                if (push[q]) begin
                    wr_ptr_q[q] <= wr_ptr_q[q] + 1'b1;
                end
                if (pop[q]) begin
                    rd_ptr_q[q] <= rd_ptr_q[q] + 1'b1;
                end
                case ({push[q], pop[q]})
                    2'b10:   cnt_q[q] <= cnt_q[q] + 1'b1;
                    2'b01:   cnt_q[q] <= cnt_q[q] - 1'b1;
                    default: cnt_q[q] <= cnt_q[q];
                endcase
            end
        end
    end

    assign cdb_o = cdb_q;

    // depth matches the rob, so a full queue must never take more
    for (genvar g = 0; g < 2; g++) begin : g_ovf
        a_no_overflow: assert property (
            @(posedge clk) disable iff (rst)
            (push[g] && !pop[g]) |-> (cnt_q[g] != CNT_W'(ROB_DEPTH))
        ) else $error("result queue %0d overflow", g);
    end

endmodule

// ==== source/ooo_backend_top.sv ====
`timescale 1ns/1ps

module ooo_backend_top #(
    parameter int ROB_DEPTH  = 8,
    parameter int MUL_STAGES = 3
) (
    input  logic               clk,
    input  logic               rst,
    input  ooo_pkg::dispatch_t dispatch_i,
    output ooo_pkg::commit_t   commit_o,
    output logic               full_o
);
    import ooo_pkg::*;

    issue_t  alu_issue;
    issue_t  mul_issue;
    result_t alu_result;
    result_t mul_result;
    // shared result bus back to the rob
    result_t cdb;

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clk         (clk),
        .rst         (rst),
        .dispatch_i  (dispatch_i),
        .cdb_i       (cdb),
        .alu_issue_o (alu_issue),
        .mul_issue_o (mul_issue),
        .commit_o    (commit_o),
        .full_o      (full_o)
    );

    alu_unit u_alu (
        .clk      (clk),
        .rst      (rst),
        .issue_i  (alu_issue),
        .result_o (alu_result)
    );

    mul_unit #(
        .MUL_STAGES (MUL_STAGES)
    ) u_mul (
        .clk      (clk),
        .rst      (rst),
        .issue_i  (mul_issue),
        .result_o (mul_result)
    );

    // queues sized like the rob so no result is ever refused
    cdb_arbiter #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_arb (
        .clk          (clk),
        .rst          (rst),
        .alu_result_i (alu_result),
        .mul_result_i (mul_result),
        .cdb_o        (cdb)
    );

endmodule

// ==== verif/tb_ooo_backend.sv ====
`timescale 1ns/1ps

module tb_ooo_backend;
    import ooo_pkg::*;

    localparam int ROB_DEPTH    = 8;
    localparam int MUL_STAGES   = 3;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_ENTRIES  = 64;
    localparam int FIELDS       = 6;
    // trace lines sent back to back
    localparam int BURST_FIRST  = 10;
    localparam int BURST_LAST   = 25;

    logic        clk;
    logic        rst;
    dispatch_t   dispatch_i;
    commit_t     commit_o;
    logic        full_o;

    logic [31:0] trace_mem [MAX_ENTRIES*FIELDS];
    int          drive_cycle [MAX_ENTRIES];
    int          num_entries;
    int          cycle;
    int          limit;
    int          next_idx;
    int          driven_cnt;
    int          commit_cnt;
    int          gap_left;
    int          occupancy;
    logic [7:0]  lfsr;

    ooo_backend_top #(
        .ROB_DEPTH  (ROB_DEPTH),
        .MUL_STAGES (MUL_STAGES)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .dispatch_i (dispatch_i),
        .commit_o   (commit_o),
        .full_o     (full_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // fibonacci form, taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // one lfsr step per gap bit
    task automatic draw_gap(output int gap);
        lfsr = lfsr_next(lfsr);
        gap  = lfsr[0];
        lfsr = lfsr_next(lfsr);
        gap  = gap + 2 * lfsr[0];
    endtask

    // OP major opcode with the M extension funct7
    function automatic logic is_mul(input logic [31:0] word);
        return (word[6:0] == 7'b0110011) && (word[31:25] == 7'b0000001);
    endfunction

    // last two entries wait for an empty pipeline
    function automatic logic dispatch_allowed();
        return !full_o && ((driven_cnt - commit_cnt) < ROB_DEPTH) &&
               ((next_idx < num_entries - 2) || (driven_cnt == commit_cnt));
    endfunction

    task automatic check_value(input string name, input int idx,
                               input logic [31:0] actual, input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: time %0t, entry %0d, %s is %h, expected %h",
                     $time, idx, name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_commit();
        int base;
        base = commit_cnt * FIELDS;
        check_value("pc", commit_cnt, commit_o.pc, trace_mem[base]);
        check_value("rd", commit_cnt, 32'(commit_o.rd), trace_mem[base+4]);
        check_value("data", commit_cnt, commit_o.data, trace_mem[base+5]);
        // slots are handed out in order from zero
        check_value("tag", commit_cnt, 32'(commit_o.tag), 32'(commit_cnt % ROB_DEPTH));
        if (commit_cnt >= num_entries - 2) begin
            check_value("latency", commit_cnt, 32'(cycle - 1 - drive_cycle[commit_cnt]),
                        is_mul(trace_mem[base+1]) ? 32'(MUL_STAGES + 3) : 32'd4);
        end
    endtask

    task automatic drive_entry();
        int base;
        base = next_idx * FIELDS;
        dispatch_i.valid   <= 1'b1;
        dispatch_i.pc      <= trace_mem[base];
        dispatch_i.inst    <= trace_mem[base+1];
        dispatch_i.rs1_val <= trace_mem[base+2];
        dispatch_i.rs2_val <= trace_mem[base+3];
        dispatch_i.rd      <= trace_mem[base+4][4:0];
        drive_cycle[next_idx] = cycle;
        if ((next_idx >= BURST_FIRST) && (next_idx < BURST_LAST)) begin
            gap_left = 0;
        end else begin
            draw_gap(gap_left);
        end
        next_idx++;
        driven_cnt++;
    endtask

    initial begin
        rst         = 1'b1;
        dispatch_i  = '0;
        lfsr        = 8'd50;
        cycle       = 0;
        next_idx    = 0;
        driven_cnt  = 0;
        commit_cnt  = 0;
        gap_left    = 0;
        num_entries = 0;
        for (int i = 0; i < MAX_ENTRIES * FIELDS; i++) begin
            trace_mem[i] = 'x;
        end
        $readmemh("verif/backend_trace.txt", trace_mem);
        // unknown or zero pc ends the trace
        while ((num_entries < MAX_ENTRIES) && !$isunknown(trace_mem[num_entries*FIELDS]) &&
               (trace_mem[num_entries*FIELDS] != 32'h0)) begin
            num_entries++;
        end
        if (num_entries < 2) begin
            $display("the trace file holds fewer than two entries");
            $display("TB FAILED");
            $fatal(1, "empty trace");
        end
        limit = num_entries * (3 + MUL_STAGES + 3 + ROB_DEPTH) + RESET_CYCLES;

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            cycle++;
        end
        rst <= 1'b0;

        while (commit_cnt < num_entries) begin
            @(posedge clk);
            cycle++;
            if (cycle >= limit) begin
                $display("timeout, commits stopped before the end of the trace at %0d of %0d",
                         commit_cnt, num_entries);
                $display("TB FAILED");
                $fatal(1, "timeout");
            end
            if (commit_o.valid) begin
                check_commit();
                commit_cnt++;
            end
            // rob count as it stands after the previous edge
            occupancy = driven_cnt - int'(dispatch_i.valid) - commit_cnt;
            check_value("full_o", commit_cnt, 32'(full_o), 32'(occupancy == ROB_DEPTH));
            dispatch_i.valid <= 1'b0;
            if (next_idx < num_entries) begin
                if (gap_left > 0) begin
                    gap_left--;
                end else if (dispatch_allowed()) begin
                    drive_entry();
                end
            end
        end

        // watch a little longer for duplicate commits
        repeat (ROB_DEPTH + MUL_STAGES + 4) begin
            @(posedge clk);
            if (commit_o.valid) begin
                commit_cnt++;
            end
        end
        if (commit_cnt == num_entries) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("%0d commits seen for %0d trace entries", commit_cnt, num_entries);
            $display("TB FAILED");
            $fatal(1, "commit count mismatch");
        end
    end

endmodule

// ==== project.f ====
source/ooo_pkg.sv
source/reorder_buffer.sv
source/alu_unit.sv
source/mul_unit.sv
source/cdb_arbiter.sv
source/ooo_backend_top.sv
verif/tb_ooo_backend.sv

// ==== verif/backend_trace.txt ====
// columns in hex: pc inst rs1_val rs2_val rd expected_data
// entries 0 to 9 with random gaps
00001000 002081b3 00000005 00000007 03 0000000c
00001004 40208233 00000003 00000005 04 fffffffe
00001008 fff08293 00000010 deadbeef 05 0000000f
0000100c 80008313 00001000 00000000 06 00000800
00001010 0020a3b3 ffffffff 00000001 07 00000001
00001014 0020b433 ffffffff 00000001 08 00000000
00001018 4020d4b3 80000000 00000004 09 f8000000
0000101c 0020d533 80000000 00000004 0a 08000000
00001020 022085b3 00000006 00000007 0b 0000002a
00001024 00208633 00000001 00000002 0c 00000003
// entries 10 to 25 back to back
00001028 0020c6b3 ff00ff00 0f0f0f0f 0d f00ff00f
0000102c 0020e733 f0f00000 0000f0f0 0e f0f0f0f0
00001030 0020f7b3 12345678 0000ffff 0f 00005678
00001034 00209833 00000001 0000001f 10 80000000
00001038 022088b3 ffffffff 00000005 11 fffffffb
0000103c 02208933 80000000 00000003 12 80000000
00001040 022089b3 7fffffff 7fffffff 13 00000001
00001044 00208a33 7fffffff 00000001 14 80000000
00001048 fff0aa93 fffffffe 00000000 15 00000001
0000104c fff0bb13 00000005 00000000 16 00000001
00001050 4040db93 80000010 00000000 17 f8000001
00001054 0040dc13 80000010 00000000 18 08000001
00001058 fff0cc93 0000ffff 00000000 19 ffff0000
0000105c 02208d33 fffffffe fffffffd 1a 00000006
00001060 0ff0fd93 abcdef12 00000000 1b 00000012
00001064 7ff0ee13 00001000 00000000 1c 000017ff
// isolated alu then isolated mul
00001068 00208eb3 00000100 00000200 1d 00000300
0000106c 02208f33 00000100 00000200 1e 00020000
